// File: src/rv_mem_pkg.sv
`default_nettype none

package rv_mem_pkg;

    // ************************************************************
    // Memory geometry
    // ************************************************************

    localparam int main_memory_bytes = 2048;
    localparam int mem_addr_bits = $clog2(main_memory_bytes);
    localparam int mem_words = main_memory_bytes / 4;
    // Word index width, byte address minus the two lane bits
    localparam int mem_word_bits = mem_addr_bits - 2;

    // ************************************************************
    // Control codes
    // ************************************************************

    // Code 3 is never issued
    typedef enum logic [1:0] {
        result_src_alu       = 2'd0,
        result_src_memory    = 2'd1,
        result_src_pc_plus_4 = 2'd2
    } result_src_t;

    typedef enum logic [1:0] {
        mem_size_byte = 2'd0,
        mem_size_half = 2'd1,
        mem_size_word = 2'd2
    } mem_size_t;

    typedef enum logic {
        load_signed   = 1'b0,
        load_unsigned = 1'b1
    } load_sign_t;

    // ************************************************************
    // Memory word views
    // ************************************************************

    // Same 32 bits seen whole, as two halves or as four byte lanes
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] half;
        logic [3:0][7:0]  bytes;
    } mem_word_u;

endpackage

`default_nettype wire

// File: src/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [31:0]                          m_alu_result,
    input  logic [31:0]                          m_write_data,
    input  logic                                 m_mem_write,
    input  logic                                 m_reg_write,
    input  rv_mem_pkg::result_src_t              m_result_src,
    input  rv_mem_pkg::mem_size_t                m_mem_size,
    input  rv_mem_pkg::load_sign_t               m_load_sign,
    output logic [rv_mem_pkg::mem_word_bits-1:0] mem_word_addr,
    output logic [31:0]                          mem_write_data,
    output logic [3:0]                           mem_byte_en,
    output logic                                 mem_write_en,
    output rv_mem_pkg::result_src_t              w_result_src,
    output rv_mem_pkg::mem_size_t                w_mem_size,
    output rv_mem_pkg::load_sign_t               w_load_sign,
    output logic                                 w_reg_write
);
    rv_mem_pkg::mem_word_u store_word;
    logic                  mem_access;

    assign mem_word_addr = m_alu_result[rv_mem_pkg::mem_addr_bits-1:2];
    assign mem_write_en = m_mem_write;

    // Replicate the store value into every lane, byte enables pick the lane
    always_comb begin
        store_word.word = m_write_data;
        case (m_mem_size)
            rv_mem_pkg::mem_size_byte: store_word.bytes = {4{m_write_data[7:0]}};
            rv_mem_pkg::mem_size_half: store_word.half = {2{m_write_data[15:0]}};
            default: store_word.word = m_write_data;
        endcase
    end

    assign mem_write_data = store_word.word;

    always_comb begin
        case (m_mem_size)
            rv_mem_pkg::mem_size_byte: mem_byte_en = 4'b0001 << m_alu_result[1:0];
            rv_mem_pkg::mem_size_half: mem_byte_en = m_alu_result[1] ? 4'b1100 : 4'b0011;
            rv_mem_pkg::mem_size_word: mem_byte_en = 4'b1111;
            default: mem_byte_en = 4'b0000;
        endcase
    end

    // M/W control register
    always_ff @(posedge clk) begin
        if (reset) begin
            w_result_src <= rv_mem_pkg::result_src_alu;
            w_mem_size <= rv_mem_pkg::mem_size_byte;
            w_load_sign <= rv_mem_pkg::load_signed;
            w_reg_write <= 1'b0;
        end else begin
            w_result_src <= m_result_src;
            w_mem_size <= m_mem_size;
            w_load_sign <= m_load_sign;
            w_reg_write <= m_reg_write;
        end
    end

    // Only loads and stores must be aligned
    assign mem_access = m_mem_write || (m_result_src == rv_mem_pkg::result_src_memory);

    a_half_aligned: assert property (@(posedge clk) disable iff (reset)
        (mem_access && m_mem_size == rv_mem_pkg::mem_size_half) |-> !m_alu_result[0]);

    a_word_aligned: assert property (@(posedge clk) disable iff (reset)
        (mem_access && m_mem_size == rv_mem_pkg::mem_size_word) |-> m_alu_result[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: src/data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory (
    input  logic                                 clk,
    input  logic [rv_mem_pkg::mem_word_bits-1:0] mem_word_addr,
    input  logic [31:0]                          mem_write_data,
    input  logic [3:0]                           mem_byte_en,
    input  logic                                 mem_write_en,
    output logic [31:0]                          w_read_data
);
    rv_mem_pkg::mem_word_u ram [rv_mem_pkg::mem_words];
    rv_mem_pkg::mem_word_u write_word;

    assign write_word = mem_write_data;

    // ************************************************************
    // Byte-lane write port
    // ************************************************************

    always_ff @(posedge clk) begin
        if (mem_write_en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (mem_byte_en[lane]) begin
                    ram[mem_word_addr].bytes[lane] <= write_word.bytes[lane];
                end
            end
        end
    end

    // ************************************************************
    // Synchronous read port
    // ************************************************************

    // Old contents come back when reading the word being written
    always_ff @(posedge clk) begin
        w_read_data <= ram[mem_word_addr].word;
    end

    a_write_addr_known: assert property (@(posedge clk)
        mem_write_en |-> !$isunknown(mem_word_addr));

endmodule

`default_nettype wire

// File: src/writeback.sv
`timescale 1ns/1ps
`default_nettype none

module writeback (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [31:0]                          m_alu_result,
    input  logic [4:0]                           m_rd,
    input  logic [rv_mem_pkg::mem_addr_bits-1:0] m_pc_plus_4,
    input  logic [31:0]                          w_read_data,
    input  rv_mem_pkg::result_src_t              w_result_src,
    input  rv_mem_pkg::mem_size_t                w_mem_size,
    input  rv_mem_pkg::load_sign_t               w_load_sign,
    output logic [31:0]                          w_result,
    output logic [4:0]                           w_rd
);
    logic [31:0]                          w_alu_result;
    logic [rv_mem_pkg::mem_addr_bits-1:0] w_pc_plus_4;
    rv_mem_pkg::mem_word_u                read_word;
    logic [15:0]                          read_half;
    logic [7:0]                           read_byte;
    logic [31:0]                          load_data;

    // ************************************************************
    // M/W data register
    // ************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            w_alu_result <= '0;
            w_rd <= '0;
            w_pc_plus_4 <= '0;
        end else begin
            w_alu_result <= m_alu_result;
            w_rd <= m_rd;
            w_pc_plus_4 <= m_pc_plus_4;
        end
    end

    // ************************************************************
    // Load extraction and extension
    // ************************************************************

    assign read_word = w_read_data;
    assign read_half = read_word.half[w_alu_result[1]];
    assign read_byte = read_word.bytes[w_alu_result[1:0]];

    always_comb begin
        case (w_mem_size)
            rv_mem_pkg::mem_size_word: load_data = read_word.word;
            rv_mem_pkg::mem_size_half: begin
                if (w_load_sign == rv_mem_pkg::load_unsigned) begin
                    load_data = {16'h0000, read_half};
                end else begin
                    load_data = {{16{read_half[15]}}, read_half};
                end
            end
            rv_mem_pkg::mem_size_byte: begin
                if (w_load_sign == rv_mem_pkg::load_unsigned) begin
                    load_data = {24'h000000, read_byte};
                end else begin
                    load_data = {{24{read_byte[7]}}, read_byte};
                end
            end
            default: load_data = read_word.word;
        endcase
    end

    // Result select
    always_comb begin
        case (w_result_src)
            rv_mem_pkg::result_src_alu: w_result = w_alu_result;
            rv_mem_pkg::result_src_memory: w_result = load_data;
            rv_mem_pkg::result_src_pc_plus_4: begin
                w_result = {{(32 - rv_mem_pkg::mem_addr_bits){1'b0}}, w_pc_plus_4};
            end
            default: w_result = '0;
        endcase
    end

    // Control from the M stage never carries the unused code
    a_result_src_legal: assert property (@(posedge clk) disable iff (reset)
        w_result_src != 2'd3);

endmodule

`default_nettype wire

// File: src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic        clk,
    input  logic        reset,
    input  logic        w_reg_write,
    input  logic [4:0]  w_rd,
    input  logic [31:0] w_result,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);
    logic [31:0] regs [32];

    // ************************************************************
    // Write port
    // ************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (w_reg_write && w_rd != 5'd0) begin
            regs[w_rd] <= w_result;
        end
    end

    // ************************************************************
    // Read ports
    // ************************************************************

    // x0 reads zero, no bypass from the write port
    always_comb begin
        if (rs1 == 5'd0) begin
            rd1 = '0;
        end else begin
            rd1 = regs[rs1];
        end
        if (rs2 == 5'd0) begin
            rd2 = '0;
        end else begin
            rd2 = regs[rs2];
        end
    end

endmodule

`default_nettype wire

// File: src/mem_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [31:0]                          m_alu_result,
    input  logic [31:0]                          m_write_data,
    input  logic [4:0]                           m_rd,
    input  logic [rv_mem_pkg::mem_addr_bits-1:0] m_pc_plus_4,
    input  logic                                 m_mem_write,
    input  logic                                 m_reg_write,
    input  rv_mem_pkg::result_src_t              m_result_src,
    input  rv_mem_pkg::mem_size_t                m_mem_size,
    input  rv_mem_pkg::load_sign_t               m_load_sign,
    input  logic [4:0]                           rs1,
    input  logic [4:0]                           rs2,
    output logic [31:0]                          w_result,
    output logic [4:0]                           w_rd,
    output logic                                 w_reg_write,
    output logic [31:0]                          rd1,
    output logic [31:0]                          rd2
);
    logic [rv_mem_pkg::mem_word_bits-1:0] mem_word_addr;
    logic [31:0]                          mem_write_data;
    logic [3:0]                           mem_byte_en;
    logic                                 mem_write_en;
    logic [31:0]                          w_read_data;
    rv_mem_pkg::result_src_t              w_result_src;
    rv_mem_pkg::mem_size_t                w_mem_size;
    rv_mem_pkg::load_sign_t               w_load_sign;

    mem_stage u_mem_stage (
        .clk            (clk),
        .reset          (reset),
        .m_alu_result   (m_alu_result),
        .m_write_data   (m_write_data),
        .m_mem_write    (m_mem_write),
        .m_reg_write    (m_reg_write),
        .m_result_src   (m_result_src),
        .m_mem_size     (m_mem_size),
        .m_load_sign    (m_load_sign),
        .mem_word_addr  (mem_word_addr),
        .mem_write_data (mem_write_data),
        .mem_byte_en    (mem_byte_en),
        .mem_write_en   (mem_write_en),
        .w_result_src   (w_result_src),
        .w_mem_size     (w_mem_size),
        .w_load_sign    (w_load_sign),
        .w_reg_write    (w_reg_write)
    );

    data_memory u_data_memory (
        .clk            (clk),
        .mem_word_addr  (mem_word_addr),
        .mem_write_data (mem_write_data),
        .mem_byte_en    (mem_byte_en),
        .mem_write_en   (mem_write_en),
        .w_read_data    (w_read_data)
    );

    writeback u_writeback (
        .clk          (clk),
        .reset        (reset),
        .m_alu_result (m_alu_result),
        .m_rd         (m_rd),
        .m_pc_plus_4  (m_pc_plus_4),
        .w_read_data  (w_read_data),
        .w_result_src (w_result_src),
        .w_mem_size   (w_mem_size),
        .w_load_sign  (w_load_sign),
        .w_result     (w_result),
        .w_rd         (w_rd)
    );

    register_file u_register_file (
        .clk         (clk),
        .reset       (reset),
        .w_reg_write (w_reg_write),
        .w_rd        (w_rd),
        .w_result    (w_result),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd1         (rd1),
        .rd2         (rd2)
    );

endmodule

`default_nettype wire

// File: verification/mem_wb_model.svh
`ifndef mem_wb_model_svh
`define mem_wb_model_svh

`default_nettype none

// ************************************************************
// Random source and shadow state
// ************************************************************

logic [31:0]           rng_state = 32'he091;
rv_mem_pkg::mem_word_u shadow_mem [rv_mem_pkg::mem_words];
logic [31:0]           reg_model [32];

function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// Byte and half stores touch only their own lanes
function automatic void shadow_store(input logic [31:0] addr, input logic [31:0] data,
                                     input rv_mem_pkg::mem_size_t size);
    logic [rv_mem_pkg::mem_word_bits-1:0] index;
    index = addr[rv_mem_pkg::mem_addr_bits-1:2];
    case (size)
        rv_mem_pkg::mem_size_byte: shadow_mem[index].bytes[addr[1:0]] = data[7:0];
        rv_mem_pkg::mem_size_half: shadow_mem[index].half[addr[1]] = data[15:0];
        default: shadow_mem[index].word = data;
    endcase
endfunction

// ************************************************************
// Expected writeback word
// ************************************************************

function automatic logic [31:0] expected_result(
    input rv_mem_pkg::result_src_t           src,
    input rv_mem_pkg::mem_size_t             size,
    input rv_mem_pkg::load_sign_t            sign,
    input logic [31:0]                       alu,
    input logic [rv_mem_pkg::mem_addr_bits-1:0] pc4
);
    logic [31:0] word;
    logic [31:0] shifted;
    logic [31:0] loaded;
    word = shadow_mem[alu[rv_mem_pkg::mem_addr_bits-1:2]].word;
    // Addressed byte or half moved down to bit 0
    shifted = word >> (8 * alu[1:0]);
    case (size)
        rv_mem_pkg::mem_size_byte: begin
            loaded = (sign == rv_mem_pkg::load_unsigned) ? {24'h0, shifted[7:0]}
                                                         : {{24{shifted[7]}}, shifted[7:0]};
        end
        rv_mem_pkg::mem_size_half: begin
            loaded = (sign == rv_mem_pkg::load_unsigned) ? {16'h0, shifted[15:0]}
                                                         : {{16{shifted[15]}}, shifted[15:0]};
        end
        default: loaded = word;
    endcase
    case (src)
        rv_mem_pkg::result_src_alu: return alu;
        rv_mem_pkg::result_src_memory: return loaded;
        rv_mem_pkg::result_src_pc_plus_4: return 32'(pc4);
        default: return 32'h0;
    endcase
endfunction

`default_nettype wire

`endif

// File: verification/mem_wb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_tb;

    localparam int cycle_limit = 2000;

    logic                                 clk;
    logic                                 reset;
    logic [31:0]                          m_alu_result;
    logic [31:0]                          m_write_data;
    logic [4:0]                           m_rd;
    logic [rv_mem_pkg::mem_addr_bits-1:0] m_pc_plus_4;
    logic                                 m_mem_write;
    logic                                 m_reg_write;
    rv_mem_pkg::result_src_t              m_result_src;
    rv_mem_pkg::mem_size_t                m_mem_size;
    rv_mem_pkg::load_sign_t               m_load_sign;
    logic [4:0]                           rs1;
    logic [4:0]                           rs2;
    logic [31:0]                          w_result;
    logic [4:0]                           w_rd;
    logic                                 w_reg_write;
    logic [31:0]                          rd1;
    logic [31:0]                          rd2;

    int          cycle_count = 0;
    int          error_count = 0;
    int          check_count = 0;
    // Issue record holds at most one instruction in M and one in W
    int          exp_cycle_q[$];
    logic [31:0] exp_result_q[$];
    logic [4:0]  exp_rd_q[$];
    logic        exp_reg_write_q[$];

    `include "mem_wb_model.svh"

    mem_wb_top DUT (
        .clk          (clk),
        .reset        (reset),
        .m_alu_result (m_alu_result),
        .m_write_data (m_write_data),
        .m_rd         (m_rd),
        .m_pc_plus_4  (m_pc_plus_4),
        .m_mem_write  (m_mem_write),
        .m_reg_write  (m_reg_write),
        .m_result_src (m_result_src),
        .m_mem_size   (m_mem_size),
        .m_load_sign  (m_load_sign),
        .rs1          (rs1),
        .rs2          (rs2),
        .w_result     (w_result),
        .w_rd         (w_rd),
        .w_reg_write  (w_reg_write),
        .rd1          (rd1),
        .rd2          (rd2)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t ns: %s expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    // W stage holds each instruction one cycle after its issue
    always @(negedge clk) begin
        if (exp_cycle_q.size() > 0 && exp_cycle_q[0] == cycle_count - 1) begin
            check_value("w_result", exp_result_q[0], w_result);
            check_value("w_rd", exp_rd_q[0], w_rd);
            check_value("w_reg_write", exp_reg_write_q[0], w_reg_write);
            void'(exp_cycle_q.pop_front());
            void'(exp_result_q.pop_front());
            void'(exp_rd_q.pop_front());
            void'(exp_reg_write_q.pop_front());
        end
    end

    // ************************************************************
    // Stimulus tasks
    // ************************************************************

    task automatic issue(input logic [31:0] alu, input logic [31:0] wdata, input logic [4:0] rd,
                         input logic [rv_mem_pkg::mem_addr_bits-1:0] pc4,
                         input logic mem_write, input logic reg_write,
                         input rv_mem_pkg::result_src_t src, input rv_mem_pkg::mem_size_t size,
                         input rv_mem_pkg::load_sign_t sign);
        logic [31:0] expected;
        @(posedge clk);
        #5;
        m_alu_result = alu;
        m_write_data = wdata;
        m_rd = rd;
        m_pc_plus_4 = pc4;
        m_mem_write = mem_write;
        m_reg_write = reg_write;
        m_result_src = src;
        m_mem_size = size;
        m_load_sign = sign;
        // Loads see every store issued before them
        expected = expected_result(src, size, sign, alu, pc4);
        exp_cycle_q.push_back(cycle_count);
        exp_result_q.push_back(expected);
        exp_rd_q.push_back(rd);
        exp_reg_write_q.push_back(reg_write);
        if (mem_write) begin
            shadow_store(alu, wdata, size);
        end
        if (reg_write && rd != 5'd0) begin
            reg_model[rd] = expected;
        end
    endtask

    task automatic idle();
        @(posedge clk);
        #5;
        m_alu_result = '0;
        m_write_data = '0;
        m_rd = '0;
        m_pc_plus_4 = '0;
        m_mem_write = 1'b0;
        m_reg_write = 1'b0;
        m_result_src = rv_mem_pkg::result_src_alu;
        m_mem_size = rv_mem_pkg::mem_size_word;
        m_load_sign = rv_mem_pkg::load_signed;
    endtask

    task automatic drain();
        while (exp_cycle_q.size() != 0) begin
            idle();
        end
    endtask

    task automatic read_registers(input string what);
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            #5;
            rs1 = 5'(i);
            rs2 = 5'(31 - i);
            @(negedge clk);
            check_value({what, " rd1"}, reg_model[i], rd1);
            check_value({what, " rd2"}, reg_model[31 - i], rd2);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%s: %0d checks failed", name, error_count - errors_before);
    endtask

    // ************************************************************
    // Test sequence
    // ************************************************************

    initial begin
        int                     errors_before;
        logic [31:0]            r;
        logic [31:0]            data;
        logic [31:0]            addr;
        logic [31:0]            addr_list [100];
        rv_mem_pkg::mem_size_t  size;
        rv_mem_pkg::load_sign_t sign;

        reset = 1'b1;
        rs1 = '0;
        rs2 = '0;
        m_alu_result = '0;
        m_write_data = '0;
        m_rd = '0;
        m_pc_plus_4 = '0;
        m_mem_write = 1'b0;
        m_reg_write = 1'b0;
        m_result_src = rv_mem_pkg::result_src_alu;
        m_mem_size = rv_mem_pkg::mem_size_word;
        m_load_sign = rv_mem_pkg::load_signed;
        for (int i = 0; i < 32; i++) begin
            reg_model[i] = '0;
        end

        errors_before = error_count;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #5;
            check_value("reset w_rd", 32'h0, w_rd);
            check_value("reset w_result", 32'h0, w_result);
            check_value("reset w_reg_write", 32'h0, w_reg_write);
        end
        reset = 1'b0;
        read_registers("reset");
        check_value("after reset w_result", 32'h0, w_result);
        check_value("after reset w_rd", 32'h0, w_rd);
        check_value("after reset w_reg_write", 32'h0, w_reg_write);
        report_test("Test 1 reset state", errors_before);

        errors_before = error_count;
        for (int i = 0; i < 100; i++) begin
            r = next_random();
            data = next_random();
            issue(data, 32'h0, r[5:1], r[16:6], 1'b0, 1'b1,
                  r[0] ? rv_mem_pkg::result_src_pc_plus_4 : rv_mem_pkg::result_src_alu,
                  rv_mem_pkg::mem_size_word, rv_mem_pkg::load_signed);
        end
        drain();
        report_test("Test 2 ALU and PC+4 results", errors_before);

        errors_before = error_count;
        for (int i = 0; i < 100; i++) begin
            r = next_random();
            data = next_random();
            addr_list[i] = 32'(r[10:0]) & 32'h7fc;
            issue(addr_list[i], data, 5'd0, r[21:11], 1'b1, 1'b0, rv_mem_pkg::result_src_alu,
                  rv_mem_pkg::mem_size_word, rv_mem_pkg::load_signed);
        end
        for (int i = 0; i < 100; i++) begin
            r = next_random();
            issue(addr_list[i], 32'h0, r[4:0], r[15:5], 1'b0, 1'b1,
                  rv_mem_pkg::result_src_memory, rv_mem_pkg::mem_size_word,
                  rv_mem_pkg::load_signed);
        end
        drain();
        report_test("Test 3 word store and load", errors_before);

        errors_before = error_count;
        // Known contents in words 0 to 15 before partial stores
        for (int i = 0; i < 16; i++) begin
            data = next_random();
            issue(32'(i * 4), data, 5'd0, 11'd0, 1'b1, 1'b0, rv_mem_pkg::result_src_alu,
                  rv_mem_pkg::mem_size_word, rv_mem_pkg::load_signed);
        end
        for (int i = 0; i < 60; i++) begin
            r = next_random();
            data = next_random();
            size = r[0] ? rv_mem_pkg::mem_size_half : rv_mem_pkg::mem_size_byte;
            addr = 32'({r[5:2], r[7:6]});
            if (size == rv_mem_pkg::mem_size_half) begin
                addr[0] = 1'b0;
            end
            issue(addr, data, 5'd0, r[18:8], 1'b1, 1'b0, rv_mem_pkg::result_src_alu,
                  size, rv_mem_pkg::load_signed);
            // Load from the same word right in the next cycle
            case (r[20:19])
                2'd0: size = rv_mem_pkg::mem_size_byte;
                2'd1: size = rv_mem_pkg::mem_size_half;
                default: size = rv_mem_pkg::mem_size_word;
            endcase
            addr[1:0] = r[22:21];
            if (size == rv_mem_pkg::mem_size_half) begin
                addr[0] = 1'b0;
            end else if (size == rv_mem_pkg::mem_size_word) begin
                addr[1:0] = 2'b00;
            end
            sign = r[23] ? rv_mem_pkg::load_unsigned : rv_mem_pkg::load_signed;
            issue(addr, 32'h0, r[28:24], 11'(i), 1'b0, 1'b1, rv_mem_pkg::result_src_memory,
                  size, sign);
        end
        drain();
        report_test("Test 4 byte and half lanes", errors_before);

        errors_before = error_count;
        issue(32'hffff_ffff, 32'h0, 5'd0, 11'd0, 1'b0, 1'b1, rv_mem_pkg::result_src_alu,
              rv_mem_pkg::mem_size_word, rv_mem_pkg::load_signed);
        for (int i = 0; i < 100; i++) begin
            r = next_random();
            data = next_random();
            issue(data, 32'h0, r[4:0], r[15:5], 1'b0, r[16] | r[17], rv_mem_pkg::result_src_alu,
                  rv_mem_pkg::mem_size_word, rv_mem_pkg::load_signed);
        end
        drain();
        read_registers("commit");
        report_test("Test 5 register file commit", errors_before);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mem_wb_pipeline.f
src/rv_mem_pkg.sv
src/mem_stage.sv
src/data_memory.sv
src/writeback.sv
src/register_file.sv
src/mem_wb_top.sv
+incdir+verification
verification/mem_wb_tb.sv
